// ==== hw/snes_mem_pkg.sv ====
////////////////////////////////////////
// SNES memory front end shared types
// Address widths, WRAM placement and the
// 16-bit word seen as bytes
////////////////////////////////////////

package snes_mem_pkg;

    // Byte address of the shared store space
    localparam int CPU_ADDR_W = 23;

    // Word address, one bit less than the byte address
    localparam int WORD_ADDR_W = CPU_ADDR_W - 1;

    localparam int WRAM_ADDR_W = 17;    // 128KB of WRAM

    // WRAM lives at banks 7E-7F of the store
    localparam logic [CPU_ADDR_W-WRAM_ADDR_W-1:0] WRAM_PREFIX = 6'b11_1111;

    localparam int DS_W = 2;            // Byte lanes per word

    // Store word, read whole or one byte at a time
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;             // Odd byte address
            logic [7:0] lo;             // Even byte address
        } b;
    } mem_word_t;

endpackage

// ==== hw/mem_chan_if.sv ====
////////////////////////////////////////
// Word channel to the store
// Toggle req/ack, pending while they differ
////////////////////////////////////////

`timescale 1ns/100ps

interface mem_chan_if;
    import snes_mem_pkg::*;

    logic [WORD_ADDR_W-1:0] addr;
    logic [15:0]            wdata;
    logic [DS_W-1:0]        ds;     // Byte lane select
    logic                   we;
    logic                   req;
    logic                   ack;
    mem_word_t              rdata;

    modport master (output addr, wdata, ds, we, req, input ack, rdata);

    modport slave (input addr, wdata, ds, we, req, output ack, rdata);

endinterface

// ==== hw/rom_loader.sv ====
////////////////////////////////////////
// ROM loader
// Pairs streamed cartridge bytes into
// word writes and flags a finished load
////////////////////////////////////////

`timescale 1ns/100ps

module rom_loader (
    input  logic                                 mclk,
    input  logic                                 resetn,
    input  logic                                 loading,
    input  logic [7:0]                           load_data,
    input  logic                                 load_strb,
    output logic                                 loaded,
    output logic                                 wr_strb,
    output logic [snes_mem_pkg::WORD_ADDR_W-1:0] wr_addr,
    output logic [15:0]                          wr_data
);
    import snes_mem_pkg::*;

    logic [CPU_ADDR_W-1:0] load_addr;   // Next byte address
    logic [7:0]            even_byte;
    logic                  loading_r;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            load_addr <= '0;
            loading_r <= 1'b0;
            loaded    <= 1'b0;
            wr_strb   <= 1'b0;
        end else begin
            loading_r <= loading;
            wr_strb   <= 1'b0;
            if (loading && load_strb) begin
                load_addr <= load_addr + 1'b1;
                even_byte <= load_data;
                // Odd byte completes the pair
                if (load_addr[0]) begin
                    wr_strb <= 1'b1;
                    wr_addr <= load_addr[CPU_ADDR_W-1:1];
                    wr_data <= {load_data, even_byte};
                end
            end
            if (loading && !loading_r) begin   // New stream starts at 0
                load_addr <= '0;
                loaded    <= 1'b0;
            end
            if (!loading && loading_r)
                loaded <= 1'b1;
        end
    end

endmodule

// ==== hw/cpu_port_arbiter.sv ====
////////////////////////////////////////
// CPU port arbiter
// Turns ROM and WRAM bus strobes into
// store requests and steers read data
////////////////////////////////////////

`timescale 1ns/100ps

module cpu_port_arbiter (
    input  logic                                 mclk,
    input  logic                                 resetn,
    input  logic                                 loading,
    input  logic                                 wr_strb,
    input  logic [snes_mem_pkg::WORD_ADDR_W-1:0] wr_addr,
    input  logic [15:0]                          wr_data,
    input  logic [23:0]                          rom_addr,
    input  logic                                 rom_ce_n,
    input  logic                                 rom_word,
    input  logic [snes_mem_pkg::WRAM_ADDR_W-1:0] wram_addr,
    input  logic                                 wram_ce_n,
    input  logic                                 wram_rd_n,
    input  logic                                 wram_we_n,
    input  logic [7:0]                           wram_d,
    output logic [15:0]                          rom_q,
    output logic [7:0]                           wram_q,
    mem_chan_if.master                           cpu_ch
);
    import snes_mem_pkg::*;

    logic                   wram_rd;
    logic                   wram_wr;
    logic                   wram_rd_r;
    logic                   wram_wr_r;
    logic [WRAM_ADDR_W-2:0] wram_sd;    // Word address of last WRAM access
    logic [23:0]            rom_sd;     // Byte address of last ROM read
    logic                   rom_sd_vld;
    logic                   ld_pend;    // Loader write lost to WRAM
    logic                   wram_go;
    logic                   ld_go;
    logic                   rom_go;
    logic                   tag;        // 1 for WRAM
    logic                   rd_issue;
    logic                   cap_en;
    logic                   cap_port;
    mem_word_t              rom_cap;
    mem_word_t              wram_cap;

    assign wram_rd = ~wram_ce_n & ~wram_rd_n;
    assign wram_wr = ~wram_ce_n & ~wram_we_n;

    assign wram_go = (wram_rd & (~wram_rd_r | wram_addr[WRAM_ADDR_W-1:1] != wram_sd))
                   | (wram_wr & ~wram_wr_r);
    assign ld_go   = wr_strb | ld_pend;
    assign rom_go  = ~loading & ~rom_ce_n & (~rom_sd_vld | rom_addr != rom_sd);

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_ch.req <= 1'b0;
            wram_rd_r  <= 1'b0;
            wram_wr_r  <= 1'b0;
            ld_pend    <= 1'b0;
            rom_sd_vld <= 1'b0;
            rd_issue   <= 1'b0;
            cap_en     <= 1'b0;
        end else begin
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            rd_issue  <= 1'b0;
            cap_en    <= rd_issue;          // Data lands one edge after issue
            cap_port  <= tag;
            if (wram_go) begin
                cpu_ch.req   <= ~cpu_ch.req;
                cpu_ch.addr  <= {WRAM_PREFIX, wram_addr[WRAM_ADDR_W-1:1]};
                cpu_ch.wdata <= {wram_d, wram_d};
                cpu_ch.ds    <= {wram_addr[0], ~wram_addr[0]};
                cpu_ch.we    <= wram_wr;
                wram_sd      <= wram_addr[WRAM_ADDR_W-1:1];
                tag          <= 1'b1;
                rd_issue     <= ~wram_wr;
                ld_pend      <= ld_pend | wr_strb;
            end else if (ld_go) begin
                cpu_ch.req   <= ~cpu_ch.req;
                cpu_ch.addr  <= wr_addr;
                cpu_ch.wdata <= wr_data;
                cpu_ch.ds    <= 2'b11;
                cpu_ch.we    <= 1'b1;
                tag          <= 1'b0;
                ld_pend      <= 1'b0;
                rom_sd_vld   <= 1'b0;           // Force a fresh ROM read later
            end else if (rom_go) begin
                cpu_ch.req   <= ~cpu_ch.req;
                cpu_ch.addr  <= rom_addr[CPU_ADDR_W-1:1];
                cpu_ch.ds    <= 2'b11;
                cpu_ch.we    <= 1'b0;
                rom_sd       <= rom_addr;
                rom_sd_vld   <= 1'b1;
                tag          <= 1'b0;
                rd_issue     <= 1'b1;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (cap_en) begin
            if (cap_port)
                wram_cap <= cpu_ch.rdata;
            else
                rom_cap <= cpu_ch.rdata;
        end
    end

    // Byte accesses at odd addresses come back swapped
    assign rom_q  = (rom_word || !rom_addr[0]) ? rom_cap.word
                                               : {rom_cap.b.lo, rom_cap.b.hi};
    assign wram_q = wram_addr[0] ? wram_cap.b.hi : wram_cap.b.lo;

endmodule

// ==== hw/rv_word_bridge.sv ====
////////////////////////////////////////
// Soft-core word bridge
// Splits 32-bit strobed accesses into
// one or two 16-bit store requests
////////////////////////////////////////

`timescale 1ns/100ps

module rv_word_bridge (
    input  logic                                mclk,
    input  logic                                resetn,
    input  logic                                rv_valid,
    input  logic [snes_mem_pkg::CPU_ADDR_W-1:0] rv_addr,
    input  logic [31:0]                         rv_wdata,
    input  logic [3:0]                          rv_wstrb,
    output logic                                rv_ready,
    output logic [31:0]                         rv_rdata,
    mem_chan_if.master                          rv_ch
);
    import snes_mem_pkg::*;

    typedef enum logic [2:0] {
        RV_IDLE,
        RV_WAIT0,       // Low word in flight
        RV_DATA0,
        RV_WAIT1,       // High word in flight
        RV_DATA1
    } rv_state_t;

    rv_state_t       state;
    logic            rv_valid_r;
    logic            start;
    logic            wr_acc;
    logic            done;
    logic            word_sel;      // 1 selects the upper half
    logic [DS_W-1:0] ds_q;
    logic [15:0]     rdata0;

    assign start  = rv_valid & ~rv_valid_r;
    assign wr_acc = |rv_wstrb;
    assign done   = rv_ch.req == rv_ch.ack;

    assign rv_ch.addr  = {rv_addr[CPU_ADDR_W-1:2], word_sel};
    assign rv_ch.wdata = word_sel ? rv_wdata[31:16] : rv_wdata[15:0];
    assign rv_ch.ds    = ds_q;
    assign rv_ch.we    = wr_acc;

    assign rv_rdata = {rv_ch.rdata.word, rdata0};

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            state      <= RV_IDLE;
            rv_ready   <= 1'b0;
            rv_ch.req  <= 1'b0;
            rv_valid_r <= 1'b0;
        end else begin
            rv_valid_r <= rv_valid;
            rv_ready   <= 1'b0;

            case (state)
                RV_IDLE: begin
                    if (start) begin
                        rv_ch.req <= ~rv_ch.req;
                        if (wr_acc && rv_wstrb[1:0] == 2'b00) begin
                            // Upper half only
                            word_sel <= 1'b1;
                            ds_q     <= rv_wstrb[3:2];
                            state    <= RV_WAIT1;
                        end else begin
                            word_sel <= 1'b0;
                            ds_q     <= wr_acc ? rv_wstrb[1:0] : 2'b11;
                            state    <= RV_WAIT0;
                        end
                    end
                end

                RV_WAIT0: begin
                    if (done) begin
                        if (wr_acc && rv_wstrb[3:2] == 2'b00) begin
                            rv_ready <= 1'b1;       // Only the lower half was strobed
                            state    <= RV_IDLE;
                        end else begin
                            rv_ch.req <= ~rv_ch.req;
                            word_sel  <= 1'b1;
                            ds_q      <= wr_acc ? rv_wstrb[3:2] : 2'b11;
                            state     <= wr_acc ? RV_WAIT1 : RV_DATA0;
                        end
                    end
                end

                RV_DATA0: begin
                    rdata0 <= rv_ch.rdata.word;     // Still the low word here
                    state  <= RV_WAIT1;
                end

                RV_WAIT1: begin
                    if (done) begin
                        if (wr_acc) begin
                            rv_ready <= 1'b1;
                            state    <= RV_IDLE;
                        end else begin
                            state <= RV_DATA1;
                        end
                    end
                end

                RV_DATA1: begin
                    rv_ready <= 1'b1;
                    state    <= RV_IDLE;
                end

                default: state <= RV_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/word_store.sv ====
////////////////////////////////////////
// Behavioral word store
// Two toggle channels on one word array
// with byte-lane writes
////////////////////////////////////////

`timescale 1ns/100ps

module word_store #(
    parameter int STORE_AW = 16     // Word index bits kept
) (
    input  logic      mclk,
    input  logic      resetn,
    mem_chan_if.slave cpu_ch,
    mem_chan_if.slave rv_ch
);
    import snes_mem_pkg::*;

    mem_word_t           mem [2**STORE_AW];
    logic [STORE_AW-1:0] cpu_idx;       // Upper address bits alias
    logic [STORE_AW-1:0] rv_idx;
    logic                cpu_pend;
    logic                rv_pend;

    assign cpu_idx  = cpu_ch.addr[STORE_AW-1:0];
    assign rv_idx   = rv_ch.addr[STORE_AW-1:0];
    assign cpu_pend = cpu_ch.req != cpu_ch.ack;
    assign rv_pend  = rv_ch.req != rv_ch.ack;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            cpu_ch.ack <= 1'b0;
            rv_ch.ack  <= 1'b0;
        end else begin
            if (cpu_pend)
                cpu_ch.ack <= cpu_ch.req;
            if (rv_pend)
                rv_ch.ack <= rv_ch.req;
        end
    end

    // Soft-core lanes written last so they win a same-word clash
    always_ff @(posedge mclk) begin
        if (cpu_pend) begin
            if (cpu_ch.we) begin
                for (int i = 0; i < DS_W; i++)
                    if (cpu_ch.ds[i])
                        mem[cpu_idx].word[i*8 +: 8] <= cpu_ch.wdata[i*8 +: 8];
            end else begin
                cpu_ch.rdata <= mem[cpu_idx];
            end
        end
        if (rv_pend) begin
            if (rv_ch.we) begin
                for (int i = 0; i < DS_W; i++)
                    if (rv_ch.ds[i])
                        mem[rv_idx].word[i*8 +: 8] <= rv_ch.wdata[i*8 +: 8];
            end else begin
                rv_ch.rdata <= mem[rv_idx];
            end
        end
    end

endmodule

// ==== hw/snes_mem_top.sv ====
////////////////////////////////////////
// SNES memory request front end
// Loader, CPU port, soft-core bridge
// and the shared word store
////////////////////////////////////////

`timescale 1ns/100ps

module snes_mem_top #(
    parameter int STORE_AW = 16
) (
    input  logic                                mclk,
    input  logic                                resetn,
    input  logic                                loading,
    input  logic [7:0]                          load_data,
    input  logic                                load_strb,
    input  logic [23:0]                         rom_addr,
    input  logic                                rom_ce_n,
    input  logic                                rom_word,
    input  logic [16:0]                         wram_addr,
    input  logic                                wram_ce_n,
    input  logic                                wram_rd_n,
    input  logic                                wram_we_n,
    input  logic [7:0]                          wram_d,
    input  logic                                rv_valid,
    input  logic [snes_mem_pkg::CPU_ADDR_W-1:0] rv_addr,
    input  logic [31:0]                         rv_wdata,
    input  logic [3:0]                          rv_wstrb,
    output logic                                loaded,
    output logic [15:0]                         rom_q,
    output logic [7:0]                          wram_q,
    output logic                                rv_ready,
    output logic [31:0]                         rv_rdata
);
    import snes_mem_pkg::*;

    logic                   wr_strb;    // Loader word write
    logic [WORD_ADDR_W-1:0] wr_addr;
    logic [15:0]            wr_data;

    mem_chan_if cpu_ch ();
    mem_chan_if rv_ch ();

    rom_loader rom_loader_i (
        .mclk(mclk), .resetn(resetn),
        .loading(loading), .load_data(load_data), .load_strb(load_strb),
        .loaded(loaded),
        .wr_strb(wr_strb), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    cpu_port_arbiter cpu_port_arbiter_i (
        .mclk(mclk), .resetn(resetn), .loading(loading),
        .wr_strb(wr_strb), .wr_addr(wr_addr), .wr_data(wr_data),
        .rom_addr(rom_addr), .rom_ce_n(rom_ce_n), .rom_word(rom_word),
        .wram_addr(wram_addr), .wram_ce_n(wram_ce_n),
        .wram_rd_n(wram_rd_n), .wram_we_n(wram_we_n), .wram_d(wram_d),
        .rom_q(rom_q), .wram_q(wram_q),
        .cpu_ch(cpu_ch.master)
    );

    rv_word_bridge rv_word_bridge_i (
        .mclk(mclk), .resetn(resetn),
        .rv_valid(rv_valid), .rv_addr(rv_addr),
        .rv_wdata(rv_wdata), .rv_wstrb(rv_wstrb),
        .rv_ready(rv_ready), .rv_rdata(rv_rdata),
        .rv_ch(rv_ch.master)
    );

    word_store #(.STORE_AW(STORE_AW)) word_store_i (
        .mclk(mclk), .resetn(resetn),
        .cpu_ch(cpu_ch.slave),
        .rv_ch(rv_ch.slave)
    );

endmodule

// ==== bench/tb_snes_mem.sv ====
////////////////////////////////////////
// Testbench for the SNES memory front end
// Loads a ROM stream, then checks ROM,
// WRAM and soft-core accesses
////////////////////////////////////////

`timescale 1ns/100ps

module tb_snes_mem;

    localparam logic [16:0] WRAM_BASE = 17'h1_2340;

    logic        mclk;
    logic        resetn;
    logic        loading;
    logic [7:0]  load_data;
    logic        load_strb;
    logic [23:0] rom_addr;
    logic        rom_ce_n;
    logic        rom_word;
    logic [16:0] wram_addr;
    logic        wram_ce_n;
    logic        wram_rd_n;
    logic        wram_we_n;
    logic [7:0]  wram_d;
    logic        rv_valid;
    logic [22:0] rv_addr;
    logic [31:0] rv_wdata;
    logic [3:0]  rv_wstrb;
    logic        loaded;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic        rv_ready;
    logic [31:0] rv_rdata;

    logic [31:0] lfsr;
    logic [7:0]  ref_mem [0:131071];    // Byte image of the aliased store

    snes_mem_top #(.STORE_AW(16)) snes_mem_top_i (.*);

    initial begin
        mclk = 1'b0;
        forever #10 mclk = ~mclk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // ROM data is valid from the third edge after the address
    task automatic rom_check(input logic [23:0] addr, input logic word_mode);
        logic [15:0] exp;
        @(posedge mclk);
        rom_addr <= addr;
        rom_word <= word_mode;
        rom_ce_n <= 1'b0;
        repeat (3) @(posedge mclk);
        @(negedge mclk);
        if (word_mode || !addr[0])
            exp = {ref_mem[{addr[16:1], 1'b1}], ref_mem[{addr[16:1], 1'b0}]};
        else
            exp = {ref_mem[{addr[16:1], 1'b0}], ref_mem[{addr[16:1], 1'b1}]};
        check_value("rom_q", 32'(rom_q), 32'(exp));
    endtask

    task automatic wram_write(input logic [16:0] addr, input logic [7:0] d);
        @(posedge mclk);
        wram_addr <= addr;
        wram_d    <= d;
        wram_ce_n <= 1'b0;
        wram_we_n <= 1'b0;
        @(posedge mclk);
        wram_ce_n <= 1'b1;
        wram_we_n <= 1'b1;
        ref_mem[addr] = d;
    endtask

    task automatic wram_check(input logic [16:0] addr);
        @(posedge mclk);
        wram_addr <= addr;
        wram_ce_n <= 1'b0;
        wram_rd_n <= 1'b0;
        repeat (3) @(posedge mclk);
        @(negedge mclk);
        check_value("wram_q", 32'(wram_q), 32'(ref_mem[addr]));
        @(posedge mclk);
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
    endtask

    // Valid held until the one-cycle ready pulse
    task automatic rv_access(input logic [22:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [31:0] rdata);
        int   n;
        logic seen;
        @(posedge mclk);
        rv_valid <= 1'b1;
        rv_addr  <= addr;
        rv_wdata <= data;
        rv_wstrb <= strb;
        seen = 1'b0;
        for (n = 0; n < 40 && !seen; n++) begin
            @(negedge mclk);
            seen = rv_ready;
        end
        assert (seen) else abort_run("Timeout waiting for rv_ready from the bridge");
        rdata = rv_rdata;
        @(posedge mclk);
        rv_valid <= 1'b0;
        rv_wstrb <= 4'h0;
        @(negedge mclk);
        assert (!rv_ready) else abort_run("rv_ready stayed high for more than one cycle");
    endtask

    task automatic rv_write(input logic [22:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        logic [31:0] rd_dummy;
        int          k;
        for (k = 0; k < 4; k++)
            if (strb[k])
                ref_mem[{addr[16:2], 2'(k)}] = data[k*8 +: 8];
        rv_access(addr, data, strb, rd_dummy);
    endtask

    task automatic rv_read_check(input logic [22:0] addr);
        logic [31:0] got;
        logic [31:0] exp;
        exp = {ref_mem[{addr[16:2], 2'd3}], ref_mem[{addr[16:2], 2'd2}],
               ref_mem[{addr[16:2], 2'd1}], ref_mem[{addr[16:2], 2'd0}]};
        rv_access(addr, 32'h0, 4'h0, got);
        check_value("rv_rdata", got, exp);
    endtask

    initial begin
        int          i;
        int          n;
        logic        seen;
        logic [31:0] r;

        resetn    <= 1'b0;
        loading   <= 1'b0;
        load_data <= 8'h00;
        load_strb <= 1'b0;
        rom_addr  <= 24'h0;
        rom_ce_n  <= 1'b1;
        rom_word  <= 1'b0;
        wram_addr <= 17'h0;
        wram_ce_n <= 1'b1;
        wram_rd_n <= 1'b1;
        wram_we_n <= 1'b1;
        wram_d    <= 8'h00;
        rv_valid  <= 1'b0;
        rv_addr   <= 23'h0;
        rv_wdata  <= 32'h0;
        rv_wstrb  <= 4'h0;
        lfsr = 32'h7105198f;

        repeat (2) @(posedge mclk);
        resetn <= 1'b1;
        @(negedge mclk);
        check_value("rv_ready", 32'(rv_ready), 32'h0);
        check_value("loaded", 32'(loaded), 32'h0);

        // ROM stream with gaps of one to four idle cycles
        @(posedge mclk);
        loading <= 1'b1;
        for (i = 0; i < 64; i++) begin
            take_bits(2, r);
            for (n = 0; n <= r; n++) begin
                @(posedge mclk);
                load_strb <= 1'b0;
            end
            take_bits(8, r);
            @(posedge mclk);
            load_strb <= 1'b1;
            load_data <= r[7:0];
            ref_mem[17'(i)] = r[7:0];
            @(negedge mclk);
            check_value("loaded", 32'(loaded), 32'h0);
        end
        @(posedge mclk);
        load_strb <= 1'b0;
        loading   <= 1'b0;
        seen = 1'b0;
        for (n = 0; n < 10 && !seen; n++) begin
            @(negedge mclk);
            seen = loaded;
        end
        assert (seen) else abort_run("Timeout waiting for loaded after the ROM stream");

        for (i = 0; i < 64; i += 2)
            rom_check(24'(i), 1'b1);
        for (i = 1; i < 64; i += 2)
            rom_check(24'(i), 1'b0);            // Odd byte reads come back swapped
        @(posedge mclk);
        rom_ce_n <= 1'b1;

        // Each WRAM byte is read back after a write to its neighbor
        for (i = 0; i < 8; i += 2) begin
            take_bits(24, r);
            wram_write(17'(WRAM_BASE + 17'(i)), r[7:0]);
            wram_write(17'(WRAM_BASE + 17'(i + 1)), r[15:8]);
            wram_check(17'(WRAM_BASE + 17'(i)));
            wram_write(17'(WRAM_BASE + 17'(i)), r[23:16]);
            wram_check(17'(WRAM_BASE + 17'(i + 1)));
            wram_check(17'(WRAM_BASE + 17'(i)));
        end
        for (i = 0; i < 64; i += 2)
            rom_check(24'(i), 1'b1);
        @(posedge mclk);
        rom_ce_n <= 1'b1;

        take_bits(32, r);
        rv_write(23'h2_8100, r, 4'hf);          // Aliases onto 0x08100
        rv_read_check(23'h2_8100);
        rv_read_check(23'h0);

        take_bits(32, r);
        rv_write(23'h0_8200, r, 4'hf);
        take_bits(32, r);
        rv_write(23'h0_8200, r, 4'b0011);       // Low half only
        rv_read_check(23'h0_8200);
        take_bits(32, r);
        rv_write(23'h0_8200, r, 4'b1100);       // High half only
        rv_read_check(23'h0_8200);
        take_bits(32, r);
        rv_write(23'h0_8200, r, 4'b0110);
        rv_read_check(23'h0_8200);
        take_bits(32, r);
        rv_write(23'h0_8200, r, 4'b1001);
        rv_read_check(23'h0_8200);

        // Same word seen through the CPU port
        rom_check(24'h80_8200, 1'b1);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== project.f ====
hw/snes_mem_pkg.sv
hw/mem_chan_if.sv
hw/rom_loader.sv
hw/cpu_port_arbiter.sv
hw/rv_word_bridge.sv
hw/word_store.sv
hw/snes_mem_top.sv
bench/tb_snes_mem.sv

// ==== Makefile ====
TOP = tb_snes_mem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
